//--- src/i2c_bus_pkg.sv
`default_nettype none

package i2c_bus_pkg;

    parameter int BYTE_W = 8;                   // bits per byte on the bus
    parameter int ADDR_W = 7;                   // 7-bit target address

    // command byte fields, MSB first on the wire
    typedef struct packed {
        logic [ADDR_W-1:0] addr;                // target address
        logic              rw;                  // 1 = master reads
    } i2c_cmd_fields_t;

    // command byte seen either as raw shift data or as decoded fields
    typedef union packed {
        logic [BYTE_W-1:0] raw;
        i2c_cmd_fields_t   f;
    } i2c_cmd_u;

    // synchronized bus levels and events from the line sampler
    typedef struct packed {
        logic scl;                              // synchronized scl level
        logic sda;                              // synchronized sda level
        logic scl_rise;                         // one-cycle pulse
        logic scl_fall;                         // one-cycle pulse
        logic sda_rise;                         // one-cycle pulse
        logic sda_fall;                         // one-cycle pulse
        logic drive_pt;                         // target may change sda now
    } i2c_line_ev_t;

endpackage

`default_nettype wire

//--- src/i2c_target_pkg.sv
`default_nettype none

package i2c_target_pkg;

    // status seen by the user logic behind the target
    typedef struct packed {
        logic                              busy;     // transaction in progress
        logic                              data_vl;  // one-cycle data strobe
        logic                              rw;       // from command byte
        logic [i2c_bus_pkg::ADDR_W-1:0]    addr_slv; // address from command byte
        logic [i2c_bus_pkg::BYTE_W-1:0]    addr_reg; // register address of the byte
        logic [i2c_bus_pkg::BYTE_W-1:0]    data_rd;  // byte written by the master
    } i2c_target_status_t;

endpackage

`default_nettype wire

//--- src/i2c_line_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_line_sampler #(
    parameter int SYNC_STAGES = 2,
    parameter int DRIVE_DLY   = 4
) (
    input  logic                      CLK,
    input  logic                      RST_n,
    input  logic                      scl,
    input  logic                      sda,
    output i2c_bus_pkg::i2c_line_ev_t line_ev
);

    localparam int CNT_W = $clog2(DRIVE_DLY + 1);

    logic [1:0]       pin_sync [SYNC_STAGES];     // bit 1 is scl, bit 0 is sda
    logic [1:0]       pin_lvl;                    // last synchronizer stage
    logic [1:0]       pin_prev;                   // level one cycle earlier
    logic [1:0]       pin_rise;
    logic [1:0]       pin_fall;
    logic [CNT_W-1:0] dly_cnt;                    // 0 when no drive point pending

    assign pin_lvl  = pin_sync[SYNC_STAGES-1];
    assign pin_prev = {line_ev.scl, line_ev.sda};
    assign pin_rise = pin_lvl & ~pin_prev;
    assign pin_fall = ~pin_lvl & pin_prev;

    always_ff @(posedge CLK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            for (int i = 0; i < SYNC_STAGES; i++)
                pin_sync[i] <= 2'b11;             // idle bus is high
            line_ev <= '{scl: 1'b1, sda: 1'b1, default: 1'b0};
            dly_cnt <= '0;
        end
        else
        begin
            pin_sync[0] <= {scl, sda};
            for (int i = 1; i < SYNC_STAGES; i++)
                pin_sync[i] <= pin_sync[i-1];

            line_ev.scl      <= pin_lvl[1];
            line_ev.sda      <= pin_lvl[0];
            line_ev.scl_rise <= pin_rise[1];
            line_ev.scl_fall <= pin_fall[1];
            line_ev.sda_rise <= pin_rise[0];
            line_ev.sda_fall <= pin_fall[0];

            // drive point lands DRIVE_DLY cycles after the scl_fall pulse
            line_ev.drive_pt <= (dly_cnt == CNT_W'(1));
            if (pin_fall[1])
                dly_cnt <= CNT_W'(DRIVE_DLY);
            else if (dly_cnt != '0)
                dly_cnt <= dly_cnt - 1'b1;
        end
    end

    // drive point has to land inside the scl low phase
    a_drive_in_scl_low: assert property (
        @(posedge CLK) disable iff (!RST_n)
        line_ev.drive_pt |-> !line_ev.scl
    );

endmodule

`default_nettype wire

//--- src/i2c_target_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_target_fsm (
    input  logic                              CLK,
    input  logic                              RST_n,
    input  i2c_bus_pkg::i2c_line_ev_t         line_ev,
    input  logic                              ack,
    input  logic [i2c_bus_pkg::BYTE_W-1:0]    data_wr,
    output logic                              sda_o,
    output i2c_target_pkg::i2c_target_status_t status
);

    import i2c_bus_pkg::*;

    localparam int CNT_W = $clog2(BYTE_W + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CMD,                                   // command byte in
        ST_CMD_ACK,
        ST_PTR,                                   // register pointer byte in
        ST_WACK,                                  // ack after pointer or data
        ST_RX,                                    // write data in
        ST_TX,                                    // read data out
        ST_MACK                                   // ack/nack from master
    } state_t;

    state_t            state;
    logic [BYTE_W-1:0] rx_sr;                     // receive shift register
    logic [BYTE_W-1:0] rx_next;
    logic [BYTE_W-1:0] tx_sr;                     // transmit shift register
    logic [BYTE_W-1:0] ptr;                       // register pointer
    logic [CNT_W-1:0]  bit_cnt;
    logic              ack_lvl;                   // ack level for this transaction
    logic              start_ev;
    logic              stop_ev;
    logic              rx_state;
    logic              byte_full;
    logic              rx_bit;
    logic              rx_last;
    logic              rd_nack;
    logic              tx_load;
    logic              tx_shift;
    i2c_cmd_u          cmd;

    assign start_ev  = line_ev.sda_fall && line_ev.scl;
    assign stop_ev   = line_ev.sda_rise && line_ev.scl;
    assign rx_state  = (state == ST_CMD) || (state == ST_PTR) || (state == ST_RX);
    assign byte_full = (bit_cnt == CNT_W'(BYTE_W));
    assign rx_bit    = rx_state && line_ev.scl_rise && !byte_full;
    assign rx_last   = rx_bit && (bit_cnt == CNT_W'(BYTE_W - 1));
    assign rx_next   = {rx_sr[BYTE_W-2:0], line_ev.sda};
    assign rd_nack   = (state == ST_MACK) && line_ev.scl_rise && line_ev.sda;
    assign cmd.raw   = rx_sr;

    // next read byte is fetched after the command ack or after a master ack
    assign tx_load  = line_ev.drive_pt &&
                      (((state == ST_CMD_ACK) && status.rw && !ack_lvl) ||
                       (state == ST_MACK));
    assign tx_shift = line_ev.drive_pt && (state == ST_TX) && !byte_full;

    always_ff @(posedge CLK)
    begin
        if (rx_bit)
            rx_sr <= rx_next;
        if (tx_load)
            tx_sr <= {data_wr[BYTE_W-2:0], 1'b0};
        else if (tx_shift)
            tx_sr <= {tx_sr[BYTE_W-2:0], 1'b0};
    end

    always_ff @(posedge CLK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            ack_lvl <= 1'b1;
            ptr     <= '0;
            sda_o   <= 1'b1;
            status  <= '0;
        end
        else
        begin
            status.data_vl <= 1'b0;
            if (stop_ev)
            begin
                state       <= ST_IDLE;
                status.busy <= 1'b0;
                sda_o       <= 1'b1;              // let go of the bus
            end
            else if (start_ev)
            begin
                state       <= ST_CMD;            // also covers repeated start
                bit_cnt     <= '0;
                status.busy <= 1'b1;
            end
            else
            begin
                if (rx_bit)
                    bit_cnt <= bit_cnt + 1'b1;
                case (state)
                    ST_CMD:
                    begin
                        if (line_ev.drive_pt && byte_full)
                        begin
                            status.addr_slv <= cmd.f.addr;
                            status.rw       <= cmd.f.rw;
                            ack_lvl         <= ack;
                            sda_o           <= ack;
                            state           <= ST_CMD_ACK;
                        end
                    end
                    ST_CMD_ACK:
                    begin
                        if (line_ev.drive_pt)
                        begin
                            bit_cnt <= '0;
                            if (!status.rw)
                            begin
                                sda_o <= 1'b1;
                                state <= ST_PTR;
                            end
                            else if (tx_load)
                            begin
                                sda_o   <= data_wr[BYTE_W-1]; // MSB goes first
                                bit_cnt <= CNT_W'(1);
                                state   <= ST_TX;
                            end
                            else
                            begin
                                sda_o <= 1'b1;    // read not acked, wait for stop
                                state <= ST_IDLE;
                            end
                        end
                    end
                    ST_PTR:
                    begin
                        if (line_ev.drive_pt && byte_full)
                        begin
                            ptr             <= rx_sr;
                            status.addr_reg <= rx_sr;
                            sda_o           <= ack_lvl;
                            state           <= ST_WACK;
                        end
                    end
                    ST_WACK:
                    begin
                        if (line_ev.drive_pt)
                        begin
                            sda_o   <= 1'b1;
                            bit_cnt <= '0;
                            state   <= ST_RX;
                        end
                    end
                    ST_RX:
                    begin
                        if (rx_last)
                        begin
                            status.data_rd  <= rx_next;
                            status.addr_reg <= ptr;
                            status.data_vl  <= 1'b1;
                            ptr             <= ptr + 1'b1; // auto-increment
                        end
                        if (line_ev.drive_pt && byte_full)
                        begin
                            sda_o <= ack_lvl;
                            state <= ST_WACK;
                        end
                    end
                    ST_TX:
                    begin
                        if (tx_shift)
                        begin
                            sda_o   <= tx_sr[BYTE_W-1];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        else if (line_ev.drive_pt)
                        begin
                            sda_o <= 1'b1;        // release for master ack
                            state <= ST_MACK;
                        end
                    end
                    ST_MACK:
                    begin
                        if (rd_nack)
                        begin
                            sda_o       <= 1'b1;
                            status.busy <= 1'b0;
                            state       <= ST_IDLE;
                        end
                        else if (line_ev.scl_rise)
                        begin
                            status.addr_reg <= status.addr_reg + 1'b1;
                            status.data_vl  <= 1'b1;
                        end
                        if (tx_load)
                        begin
                            sda_o   <= data_wr[BYTE_W-1];
                            bit_cnt <= CNT_W'(1);
                            state   <= ST_TX;
                        end
                    end
                    default:
                    begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    a_vl_in_busy: assert property (
        @(posedge CLK) disable iff (!RST_n)
        status.data_vl |-> status.busy
    );

    // sda only moves while scl is low, or when the bus is handed back
    a_sda_change_point: assert property (
        @(posedge CLK) disable iff (!RST_n)
        $changed(sda_o) |-> $past(line_ev.drive_pt || stop_ev || rd_nack)
    );

endmodule

`default_nettype wire

//--- src/i2c_target_top.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_target_top #(
    parameter int SYNC_STAGES = 2,                // synchronizer depth
    parameter int DRIVE_DLY   = 4                 // below the scl low time
) (
    input  logic                               CLK,
    input  logic                               RST_n,
    input  logic                               scl,
    input  logic                               sda,
    input  logic                               ack,
    input  logic [i2c_bus_pkg::BYTE_W-1:0]     data_wr,
    output logic                               sda_o,
    output i2c_target_pkg::i2c_target_status_t status
);

    import i2c_bus_pkg::*;

    i2c_line_ev_t line_ev;                        // sampler to fsm

    i2c_line_sampler #(
        .SYNC_STAGES (SYNC_STAGES),
        .DRIVE_DLY   (DRIVE_DLY)
    ) u_sampler (
        .CLK     (CLK),
        .RST_n   (RST_n),
        .scl     (scl),
        .sda     (sda),
        .line_ev (line_ev)
    );

    i2c_target_fsm u_fsm (
        .CLK     (CLK),
        .RST_n   (RST_n),
        .line_ev (line_ev),
        .ack     (ack),
        .data_wr (data_wr),
        .sda_o   (sda_o),
        .status  (status)
    );

endmodule

`default_nettype wire

//--- include/i2c_master_tasks.svh
`ifndef I2C_MASTER_TASKS_SVH
`define I2C_MASTER_TASKS_SVH

// bus levels held for n quarter bits
task automatic wait_quarters(input int n);
    repeat (n * QB) @(negedge CLK);
endtask

task automatic send_start();
    m_sda = 1'b0;                                 // sda falls while scl is high
    wait_quarters(1);
    m_scl = 1'b0;
    wait_quarters(1);
endtask

task automatic send_stop();
    wait_quarters(1);
    m_sda = 1'b0;
    wait_quarters(1);
    m_scl = 1'b1;
    wait_quarters(1);
    m_sda = 1'b1;                                 // sda rises while scl is high
    wait_quarters(1);
endtask

// one scl pulse, sda set a quarter bit into the low phase
task automatic clock_bit(input logic sda_lvl, output logic sampled);
    wait_quarters(1);
    m_sda = sda_lvl;
    wait_quarters(1);
    m_scl = 1'b1;
    wait_quarters(1);
    sampled = sda_bus;                            // middle of scl high
    wait_quarters(1);
    m_scl = 1'b0;
endtask

task automatic write_byte(input logic [BYTE_W-1:0] data, output logic acked);
    logic echo;
    for (int i = BYTE_W - 1; i >= 0; i--)
        clock_bit(data[i], echo);
    wait_quarters(1);
    m_sda = 1'b1;                                 // release for the target ack
    wait_quarters(1);
    m_scl    = 1'b1;
    ack_slot = 1'b1;
    wait_quarters(1);
    acked = !sda_bus;
    wait_quarters(1);
    m_scl    = 1'b0;
    ack_slot = 1'b0;
endtask

task automatic read_byte(input logic nack, output logic [BYTE_W-1:0] data);
    logic bit_in;
    for (int i = BYTE_W - 1; i >= 0; i--)
    begin
        clock_bit(1'b1, bit_in);
        data[i] = bit_in;
    end
    clock_bit(nack, bit_in);                      // master ack or nack
endtask

`endif

//--- tests/i2c_target_tb.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_target_tb;

    import i2c_bus_pkg::*;
    import i2c_target_pkg::*;

    localparam int QB          = 10;                // clk cycles per quarter bit
    localparam int CLK_NS      = 40;
    localparam int BIT_NS      = 4 * QB * CLK_NS;
    localparam int BUS_BITS    = 12 * 9 + 3 * 4;    // 12 bytes plus start, stop and gaps
    localparam int WATCHDOG_NS = 10 * BUS_BITS * BIT_NS; // ten times the bus time
    localparam int MON_NONE    = 0;
    localparam int MON_WRITE   = 1;
    localparam int MON_READ    = 2;

    logic               CLK = 1'b0;
    logic               RST_n;
    logic               m_scl;                      // master scl, never stretched
    logic               m_sda;                      // master sda drive
    logic               sda_bus;                    // wired-and of both drivers
    logic               ack;
    logic [BYTE_W-1:0]  data_wr;
    logic               sda_o;
    i2c_target_status_t status;

    logic               ack_slot     = 1'b0;        // ninth scl high of a master write
    logic               expect_ack   = 1'b0;
    logic               hold_release = 1'b0;        // target must stay off the bus
    logic               in_xfer      = 1'b0;
    logic               bus_idle     = 1'b0;
    string              test_name    = "reset";
    int                 mon_mode     = MON_NONE;
    int                 main_errors  = 0;
    int                 mon_errors   = 0;
    int                 sva_errors   = 0;
    logic [BYTE_W-1:0]  wr_bytes [4];
    logic [BYTE_W-1:0]  rd_bytes [4];
    logic [1:0]         wr_idx       = '0;
    logic [1:0]         rd_idx       = '0;          // byte currently on data_wr
    int                 wr_ptr       = 0;
    int                 rd_base      = 0;
    i2c_cmd_u           cmd;

    assign sda_bus = m_sda & sda_o;
    assign data_wr = rd_bytes[rd_idx];

    always #(CLK_NS / 2) CLK = ~CLK;

    i2c_target_top UUT (
        .CLK     (CLK),
        .RST_n   (RST_n),
        .scl     (m_scl),
        .sda     (sda_bus),
        .ack     (ack),
        .data_wr (data_wr),
        .sda_o   (sda_o),
        .status  (status)
    );

    `include "i2c_master_tasks.svh"

    function automatic bit value_ok(input string name, input int expected, input int actual);
        bit ok;
        ok = (expected == actual);
        assert (ok)
        else
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
        return ok;
    endfunction

    a_ack_driven: assert property (
        @(posedge CLK) disable iff (!RST_n)
        (ack_slot && expect_ack) |-> !sda_o
    )
    else
    begin
        sva_errors++;
        $display("CHECK FAILED %s ack slot: expected sda_o 0, actual 1", test_name);
    end

    a_nack_released: assert property (
        @(posedge CLK) disable iff (!RST_n)
        hold_release |-> sda_o
    )
    else
    begin
        sva_errors++;
        $display("CHECK FAILED %s sda_o: expected 1, actual 0", test_name);
    end

    a_busy_in_xfer: assert property (
        @(posedge CLK) disable iff (!RST_n)
        in_xfer |-> status.busy
    )
    else
    begin
        sva_errors++;
        $display("CHECK FAILED %s busy: expected 1, actual 0", test_name);
    end

    a_idle_not_busy: assert property (
        @(posedge CLK) disable iff (!RST_n)
        bus_idle |-> !status.busy
    )
    else
    begin
        sva_errors++;
        $display("CHECK FAILED %s idle busy: expected 0, actual 1", test_name);
    end

    // data strobes check write bytes and step the read source
    always @(negedge CLK)
    begin
        if (RST_n && status.data_vl)
        begin
            if (mon_mode == MON_WRITE)
            begin
                if (!value_ok($sformatf("write byte %0d data_rd", wr_idx),
                              int'(wr_bytes[wr_idx]), int'(status.data_rd)))
                    mon_errors++;
                if (!value_ok($sformatf("write byte %0d addr_reg", wr_idx),
                              (wr_ptr + int'(wr_idx)) & 'hFF, int'(status.addr_reg)))
                    mon_errors++;
                wr_idx++;
            end
            else if (mon_mode == MON_READ)
            begin
                if (!value_ok($sformatf("read ack %0d addr_reg", rd_idx),
                              (rd_base + int'(rd_idx) + 1) & 'hFF, int'(status.addr_reg)))
                    mon_errors++;
                rd_idx++;                           // next random byte onto data_wr
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the bus sequence finished");
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        logic              acked;
        logic [BYTE_W-1:0] got;
        void'($urandom(32'h5071_2234));
        RST_n = 1'b0;
        m_scl = 1'b1;                               // idle bus
        m_sda = 1'b1;
        ack   = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            wr_bytes[i] = BYTE_W'($urandom);
            rd_bytes[i] = BYTE_W'($urandom);
        end
        repeat (4) @(negedge CLK);
        RST_n = 1'b1;
        @(negedge CLK);
        if (!value_ok("reset busy", 0, int'(status.busy)))
            main_errors++;
        if (!value_ok("reset data_vl", 0, int'(status.data_vl)))
            main_errors++;
        if (!value_ok("reset sda_o", 1, int'(sda_o)))
            main_errors++;
        bus_idle = 1'b1;
        wait_quarters(4);

        test_name  = "write";
        cmd.f.addr = ADDR_W'($urandom);
        cmd.f.rw   = 1'b0;
        wr_ptr     = int'($urandom % 256);
        expect_ack = 1'b1;
        mon_mode   = MON_WRITE;
        bus_idle   = 1'b0;
        send_start();
        in_xfer = 1'b1;
        write_byte(cmd.raw, acked);
        write_byte(BYTE_W'(wr_ptr), acked);
        for (int k = 0; k < 3; k++)
            write_byte(wr_bytes[k], acked);
        in_xfer = 1'b0;
        send_stop();
        bus_idle   = 1'b1;
        mon_mode   = MON_NONE;
        expect_ack = 1'b0;
        if (!value_ok("write addr_slv", int'(cmd.f.addr), int'(status.addr_slv)))
            main_errors++;
        if (!value_ok("write rw", 0, int'(status.rw)))
            main_errors++;
        if (!value_ok("write data_vl count", 3, int'(wr_idx)))
            main_errors++;
        wait_quarters(4);

        test_name  = "read";
        cmd.f.addr = ADDR_W'($urandom);
        cmd.f.rw   = 1'b1;
        rd_base    = (wr_ptr + 2) & 'hFF;           // last write strobe carried P+2
        expect_ack = 1'b1;
        mon_mode   = MON_READ;
        bus_idle   = 1'b0;
        send_start();
        in_xfer = 1'b1;
        write_byte(cmd.raw, acked);
        expect_ack = 1'b0;
        for (int k = 0; k < 3; k++)
        begin
            if (k == 2)
                in_xfer = 1'b0;                     // busy drops at the nack
            read_byte(k == 2, got);
            if (!value_ok($sformatf("read byte %0d", k), int'(rd_bytes[k]), int'(got)))
                main_errors++;
        end
        if (!value_ok("read busy after nack", 0, int'(status.busy)))
            main_errors++;
        if (!value_ok("read ack count", 2, int'(rd_idx)))
            main_errors++;
        if (!value_ok("read addr_slv", int'(cmd.f.addr), int'(status.addr_slv)))
            main_errors++;
        if (!value_ok("read rw", 1, int'(status.rw)))
            main_errors++;
        send_stop();
        bus_idle = 1'b1;
        mon_mode = MON_NONE;
        wait_quarters(4);

        test_name    = "nack";
        cmd.f.addr   = ADDR_W'($urandom);
        cmd.f.rw     = 1'b0;
        ack          = 1'b1;
        hold_release = 1'b1;
        bus_idle     = 1'b0;
        send_start();
        in_xfer = 1'b1;
        write_byte(cmd.raw, acked);
        if (!value_ok("nack command ack", 0, int'(acked)))
            main_errors++;
        write_byte(BYTE_W'($urandom), acked);
        write_byte(BYTE_W'($urandom), acked);
        in_xfer = 1'b0;
        send_stop();
        bus_idle     = 1'b1;
        hold_release = 1'b0;
        if (!value_ok("nack addr_slv", int'(cmd.f.addr), int'(status.addr_slv)))
            main_errors++;
        wait_quarters(4);

        $display("errors: %0d check, %0d monitor, %0d assertion",
                 main_errors, mon_errors, sva_errors);
        if (main_errors + mon_errors + sva_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- i2c_target.f
+incdir+include
src/i2c_bus_pkg.sv
src/i2c_target_pkg.sv
src/i2c_line_sampler.sv
src/i2c_target_fsm.sv
src/i2c_target_top.sv
tests/i2c_target_tb.sv

//--- Makefile
TOP = i2c_target_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f i2c_target.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
